/* Makefile */
# Verilator flow for the CTR counter unit testbench
SIM  = obj_dir/Vctr_unit_tb
SRCS = $(shell cat ctr_unit.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): ctr_unit.f $(SRCS)
	verilator --binary --timing --assert -Mdir obj_dir --top-module ctr_unit_tb -f ctr_unit.f

# Passes only when the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* ctr_unit.f */
design/ctr_pkg.sv
design/ctr_sel_check.sv
design/ctr_rail_fsm.sv
design/ctr_rail_merge.sv
design/ctr_incr.sv
design/ctr_unit.sv
testbench/tb_clock_gen.sv
testbench/ctr_unit_tb.sv

/* design/ctr_incr.sv */
/*
  Sliced increment of a big-endian counter block
  Byte 0 sits in bits 7:0 and is the most significant byte
  Block width must be a multiple of 8 bits
  Requests are only registered while ready_o is SP2V_HIGH
*/
`timescale 1ns/10ps

module ctr_incr #(
  parameter int NumSlices = ctr_pkg::NumSlicesCtr,
  parameter int SliceSize = ctr_pkg::SliceSizeCtr
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  ctr_pkg::sp2v_e                  incr_i,
  input  logic [NumSlices*SliceSize-1:0]  ctr_i,
  output ctr_pkg::sp2v_e                  ready_o,
  output logic                            alert_o,
  output logic [NumSlices*SliceSize-1:0]  ctr_o,
  output ctr_pkg::sp2v_e [NumSlices-1:0]  ctr_we_o
);

  localparam int NumBytes = NumSlices * SliceSize / 8;
  localparam int W        = ctr_pkg::Sp2VWidth;

  // Swap byte order so slice 0 becomes least significant
  function automatic logic [NumBytes-1:0][7:0] rev_bytes(input logic [NumBytes-1:0][7:0] in);
    logic [NumBytes-1:0][7:0] out;
    for (int b = 0; b < NumBytes; b++) begin
      out[b] = in[NumBytes-1-b];
    end
    return out;
  endfunction

  logic [NumSlices-1:0][SliceSize-1:0] ctr_i_rev, ctr_o_rev;
  ctr_pkg::sp2v_e [NumSlices-1:0]      we_rev;
  logic [NumSlices-1:0]                we_hi;

  ctr_pkg::sp2v_e                    incr_gated, ctr_we;
  logic [W-1:0]                      sp_incr, sp_ready, sp_we, mr_alert;
  logic                              incr_err, mr_err;
  logic [W-1:0][ctr_pkg::SliceIdxWidth-1:0] mr_idx;
  logic [W-1:0][SliceSize-1:0]       mr_slice;
  logic [ctr_pkg::SliceIdxWidth-1:0] slice_idx;
  logic [SliceSize-1:0]              slice_new;

  assign ctr_i_rev = rev_bytes(ctr_i);

  // Back-pressure, a request held while busy never reaches the rails
  assign incr_gated = (ready_o == ctr_pkg::SP2V_HIGH) ? incr_i : ctr_pkg::SP2V_LOW;

  ctr_sel_check u_sel_check (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .sel_i    (incr_gated),
    .sel_o    (sp_incr),
    .err_o    (incr_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Redundant rails, one per code bit
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < W; r++) begin : gen_rail
    ctr_rail_fsm #(
      .RailPolarity (ctr_pkg::SP2V_LOGIC_HIGH[r]),
      .NumSlices    (NumSlices),
      .SliceSize    (SliceSize)
    ) u_rail (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .incr_i          (sp_incr[r]),
      .incr_err_i      (incr_err),
      .mr_err_i        (mr_err),
      .ctr_slice_i     (ctr_i_rev[slice_idx]),
      .ready_o         (sp_ready[r]),
      .alert_o         (mr_alert[r]),
      .ctr_we_o        (sp_we[r]),
      .ctr_slice_idx_o (mr_idx[r]),
      .ctr_slice_o     (mr_slice[r])
    );
  end

  ctr_rail_merge #(
    .NumSlices (NumSlices),
    .SliceSize (SliceSize)
  ) u_merge (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .rail_idx_i   (mr_idx),
    .rail_slice_i (mr_slice),
    .rail_alert_i (mr_alert),
    .slice_idx_o  (slice_idx),
    .slice_o      (slice_new),
    .alert_o      (alert_o),
    .mr_err_o     (mr_err)
  );

  // Sparse bits back into codes
  assign ready_o = ctr_pkg::sp2v_e'(sp_ready);
  assign ctr_we  = ctr_pkg::sp2v_e'(sp_we);

  // Only the addressed slice changes
  always_comb begin
    ctr_o_rev            = ctr_i_rev;
    ctr_o_rev[slice_idx] = slice_new;
    for (int s = 0; s < NumSlices; s++) begin
      we_rev[s] = ctr_pkg::SP2V_LOW;
    end
    we_rev[slice_idx] = ctr_we;
  end

  assign ctr_o = rev_bytes(ctr_o_rev);

  // Slice order flips with the bytes
  for (genvar s = 0; s < NumSlices; s++) begin : gen_we
    assign ctr_we_o[s] = we_rev[NumSlices-1-s];
    assign we_hi[s]    = (ctr_we_o[s] == ctr_pkg::SP2V_HIGH);
  end

  // Each walk starts at the least significant slice, the last one in port order
  lsb_first_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $rose(|we_hi) |-> we_hi[NumSlices-1]
  );

endmodule

/* design/ctr_pkg.sv */
/*
  Shared constants and types for the CTR-mode counter unit
  The sparse two-value code keeps a Hamming distance of 3 between legal values
  Slice geometry here is only the default, and the top level may override it
  Slice index width covers up to 8 slices
*/
package ctr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Counter geometry
  //////////////////////////////////////////////////////////////////////

  // Bits handled per clock cycle
  parameter int SliceSizeCtr  = 16;
  // Slices in one 128-bit block
  parameter int NumSlicesCtr  = 8;
  // Enough for 8 slices
  parameter int SliceIdxWidth = 3;

  //////////////////////////////////////////////////////////////////////
  // Sparse two-value encoding
  //////////////////////////////////////////////////////////////////////

  // Code width, one FSM rail per bit
  parameter int Sp2VWidth = 3;

  // Bit pattern of the high code
  // A 1 here means the rail for that bit runs active high
  parameter logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

  // Low code is the bitwise inverse of the high code
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = SP2V_LOGIC_HIGH,
    SP2V_LOW  = ~SP2V_LOGIC_HIGH
  } sp2v_e;

  //////////////////////////////////////////////////////////////////////
  // Rail FSM states
  //////////////////////////////////////////////////////////////////////

  // Encoding 2'b11 is unused and treated as an error
  typedef enum logic [1:0] {
    CTR_IDLE  = 2'b00,
    CTR_INCR  = 2'b01,
    CTR_ERROR = 2'b10
  } ctr_state_e;

endpackage

/* design/ctr_rail_fsm.sv */
/*
  One single-bit rail of the slice-walking increment FSM
  RailPolarity 0 inverts incr_i, ready_o and ctr_we_o only
  Error inputs and alert_o are always active high
  CTR_ERROR is terminal until reset
*/
`timescale 1ns/10ps

module ctr_rail_fsm #(
  parameter bit RailPolarity = 1'b1,
  parameter int NumSlices    = ctr_pkg::NumSlicesCtr,
  parameter int SliceSize    = ctr_pkg::SliceSizeCtr
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              incr_i,
  input  logic                              incr_err_i,
  input  logic                              mr_err_i,
  input  logic [SliceSize-1:0]              ctr_slice_i,
  output logic                              ready_o,
  output logic                              alert_o,
  output logic                              ctr_we_o,
  output logic [ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx_o,
  output logic [SliceSize-1:0]              ctr_slice_o
);

  localparam logic [ctr_pkg::SliceIdxWidth-1:0] LastIdx =
    ctr_pkg::SliceIdxWidth'(NumSlices - 1);

  ctr_pkg::ctr_state_e               state_d, state_q;
  logic [ctr_pkg::SliceIdxWidth-1:0] idx_d, idx_q;
  logic                              carry_d, carry_q;

  // Internal active-high view of the sparse bits
  logic incr;
  logic ready;
  logic we;

  // Slice plus registered carry, top bit is the carry out
  logic [SliceSize:0] sum;

  assign incr = RailPolarity ? incr_i : ~incr_i;

  assign sum         = {1'b0, ctr_slice_i} + {{SliceSize{1'b0}}, carry_q};
  assign ctr_slice_o = sum[SliceSize-1:0];

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin : rail_fsm
    state_d = state_q;
    idx_d   = idx_q;
    carry_d = carry_q;
    ready   = 1'b0;
    we      = 1'b0;
    alert_o = 1'b0;

    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        // Drop ready as soon as a registered request shows up
        ready = ~incr;
        if (incr) begin
          state_d = ctr_pkg::CTR_INCR;
          idx_d   = '0;
          carry_d = 1'b1;
        end
      end

      ctr_pkg::CTR_INCR: begin
        // One slice per cycle, LSB slice first
        we      = 1'b1;
        carry_d = sum[SliceSize];
        if (idx_q == LastIdx) begin
          idx_d   = '0;
          state_d = ctr_pkg::CTR_IDLE;
        end else begin
          idx_d = idx_q + 1'b1;
        end
      end

      ctr_pkg::CTR_ERROR: begin
        alert_o = 1'b1;
      end

      default: begin
        // Unused encoding
        state_d = ctr_pkg::CTR_ERROR;
        alert_o = 1'b1;
      end
    endcase

    // Bad code or rail mismatch overrides everything
    if (incr_err_i || mr_err_i) begin
      state_d = ctr_pkg::CTR_ERROR;
      ready   = 1'b0;
      we      = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ctr_pkg::CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

  // Back to sparse polarity
  assign ready_o         = RailPolarity ? ready : ~ready;
  assign ctr_we_o        = RailPolarity ? we : ~we;
  assign ctr_slice_idx_o = idx_q;

  // Index stays inside the block while walking
  idx_range_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q == ctr_pkg::CTR_INCR) |-> (idx_q <= LastIdx)
  );

endmodule

/* design/ctr_rail_merge.sv */
/*
  Combines the multi-bit outputs of all FSM rails
  Purely combinational, clock is only used by the check
  Index beyond the last slice also counts as a mismatch
*/
`timescale 1ns/10ps

module ctr_rail_merge #(
  parameter int NumSlices = ctr_pkg::NumSlicesCtr,
  parameter int SliceSize = ctr_pkg::SliceSizeCtr
) (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  input  logic [ctr_pkg::Sp2VWidth-1:0][ctr_pkg::SliceIdxWidth-1:0] rail_idx_i,
  input  logic [ctr_pkg::Sp2VWidth-1:0][SliceSize-1:0]              rail_slice_i,
  input  logic [ctr_pkg::Sp2VWidth-1:0]                             rail_alert_i,
  output logic [ctr_pkg::SliceIdxWidth-1:0]                         slice_idx_o,
  output logic [SliceSize-1:0]                                      slice_o,
  output logic                                                      alert_o,
  output logic                                                      mr_err_o
);

  localparam logic [ctr_pkg::SliceIdxWidth-1:0] LastIdx =
    ctr_pkg::SliceIdxWidth'(NumSlices - 1);

  logic [ctr_pkg::SliceIdxWidth-1:0] idx_or;
  logic [SliceSize-1:0]              slice_or;
  logic                              err;

  always_comb begin : merge_rails
    idx_or   = '0;
    slice_or = '0;
    err      = 1'b0;

    // OR first, a single faulty rail can only set bits
    for (int r = 0; r < ctr_pkg::Sp2VWidth; r++) begin
      idx_or   |= rail_idx_i[r];
      slice_or |= rail_slice_i[r];
    end

    // Then every rail must match the combined value
    for (int r = 0; r < ctr_pkg::Sp2VWidth; r++) begin
      if ((rail_idx_i[r] != idx_or) || (rail_slice_i[r] != slice_or)) begin
        err = 1'b1;
      end
    end

    if (idx_or > LastIdx) begin
      err = 1'b1;
    end
  end

  assign slice_idx_o = idx_or;
  assign slice_o     = slice_or;
  assign mr_err_o    = err;
  // One rail is enough to raise the alert
  assign alert_o     = |rail_alert_i;

  // Mismatch has to park every rail in CTR_ERROR
  mr_err_alert_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mr_err_o |=> alert_o
  );

endmodule

/* design/ctr_sel_check.sv */
/*
  Registers a sparse two-value code and flags illegal values
  Output and error flag appear one cycle after the input
  Error flag is not sticky, the rails hold the error state
*/
`timescale 1ns/10ps

module ctr_sel_check (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  ctr_pkg::sp2v_e                 sel_i,
  output logic [ctr_pkg::Sp2VWidth-1:0]  sel_o,
  output logic                           err_o
);

  logic [ctr_pkg::Sp2VWidth-1:0] sel_q;
  logic                          err_d;
  logic                          err_q;

  // Anything other than the two legal codes is an error
  assign err_d = (sel_i != ctr_pkg::SP2V_HIGH) && (sel_i != ctr_pkg::SP2V_LOW);

  // Code and flag move together so rails see both in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= ctr_pkg::SP2V_LOW;
      err_q <= 1'b0;
    end else begin
      sel_q <= sel_i;
      err_q <= err_d;
    end
  end

  // Raw bits, one per rail
  assign sel_o = sel_q;
  assign err_o = err_q;

  // Flag must resolve once out of reset
  err_known_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(err_o)
  );

endmodule

/* design/ctr_unit.sv */
/*
  CTR-mode counter unit with redundant increment control
  Byte 0 of the block is bits 7:0 and the most significant byte
  Load and increment are only taken while ready_o is SP2V_HIGH
  After an alert only reset brings the unit back
*/
`timescale 1ns/10ps

module ctr_unit #(
  parameter int NumSlices = ctr_pkg::NumSlicesCtr,
  parameter int SliceSize = ctr_pkg::SliceSizeCtr
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            load_i,
  input  logic [NumSlices*SliceSize-1:0]  load_ctr_i,
  input  ctr_pkg::sp2v_e                  incr_i,
  output ctr_pkg::sp2v_e                  ready_o,
  output logic [NumSlices*SliceSize-1:0]  ctr_o,
  output logic                            alert_o
);

  // Counter block, one row per slice
  logic [NumSlices-1:0][SliceSize-1:0] ctr_q;
  // Block with the current slice already updated
  logic [NumSlices-1:0][SliceSize-1:0] ctr_new;
  ctr_pkg::sp2v_e [NumSlices-1:0]      ctr_we;
  logic                                load_ok;

  // Host load only while idle
  assign load_ok = load_i && (ready_o == ctr_pkg::SP2V_HIGH);

  //////////////////////////////////////////////////////////////////////
  // Block register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctr_q <= '0;
    end else if (load_ok) begin
      ctr_q <= load_ctr_i;
    end else begin
      // Slice writes from the increment walk
      for (int s = 0; s < NumSlices; s++) begin
        if (ctr_we[s] == ctr_pkg::SP2V_HIGH) begin
          ctr_q[s] <= ctr_new[s];
        end
      end
    end
  end

  ctr_incr #(
    .NumSlices (NumSlices),
    .SliceSize (SliceSize)
  ) u_ctr_incr (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .incr_i   (incr_i),
    .ctr_i    (ctr_q),
    .ready_o  (ready_o),
    .alert_o  (alert_o),
    .ctr_o    (ctr_new),
    .ctr_we_o (ctr_we)
  );

  assign ctr_o = ctr_q;

endmodule

/* testbench/ctr_unit_tb.sv */
/*
  Testbench for the CTR counter unit, driven by the testdata file
  Blocks in the file are big-endian hex with byte 0 first
  File values are 128 bits, so the default 8x16 geometry is assumed
  Must run from the project root so the testdata path resolves
*/
`timescale 1ns/10ps

module ctr_unit_tb;

  localparam int NumSlices   = ctr_pkg::NumSlicesCtr;
  localparam int SliceSize   = ctr_pkg::SliceSizeCtr;
  localparam int BlockWidth  = NumSlices * SliceSize;
  localparam int ResetCycles = 10;

  typedef enum logic [2:0] {OP_LOAD, OP_INCR, OP_BAD, OP_RESET, OP_EXPECT} op_e;

  logic                  clk;
  logic                  gen_arst_n;
  logic                  soft_rst_n;
  logic                  arst_n;
  logic                  load;
  logic [BlockWidth-1:0] load_ctr;
  ctr_pkg::sp2v_e        incr;
  ctr_pkg::sp2v_e        ready;
  logic [BlockWidth-1:0] ctr;
  logic                  alert;

  // Parsed records, one entry per line of the file
  op_e                   op_q[$];
  logic [BlockWidth-1:0] val_q[$];
  int                    num_q[$];

  // Reference block, big-endian integer value
  logic [BlockWidth-1:0] exp_be;
  int                    mismatch_cnt;
  int                    fail_cnt;
  int                    budget_cycles;

  tb_clock_gen #(
    .PeriodNs    (20),
    .ResetCycles (ResetCycles)
  ) u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (gen_arst_n)
  );

  // Power-on reset or a reset record
  assign arst_n = gen_arst_n & soft_rst_n;

  ctr_unit #(
    .NumSlices (NumSlices),
    .SliceSize (SliceSize)
  ) u_ctr_unit (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .load_i     (load),
    .load_ctr_i (load_ctr),
    .incr_i     (incr),
    .ready_o    (ready),
    .ctr_o      (ctr),
    .alert_o    (alert)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Byte 0 of the block, the most significant one, sits in port bits 7:0
  function automatic logic [BlockWidth-1:0] to_port_order(input logic [BlockWidth-1:0] be);
    logic [BlockWidth-1:0] port;
    for (int b = 0; b < BlockWidth / 8; b++) begin
      port[8*b +: 8] = be[BlockWidth-8-8*b +: 8];
    end
    return port;
  endfunction

  task check_block(input string what, input logic [BlockWidth-1:0] got,
                   input logic [BlockWidth-1:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
      mismatch_cnt++;
    end
  endtask

  task check_reset_values;
    if (ready !== ctr_pkg::SP2V_HIGH) begin
      $display("MISMATCH at %0t: ready_o is %b after reset", $time, ready);
      mismatch_cnt++;
    end
    if (alert !== 1'b0) begin
      $display("MISMATCH at %0t: alert_o is %b after reset", $time, alert);
      mismatch_cnt++;
    end
    check_block("ctr_o after reset", ctr, '0);
  endtask

  task read_testdata;
    int                    fd;
    int                    n;
    logic [8*128-1:0]      line_buf;
    logic [63:0]           op;
    logic [BlockWidth-1:0] val;
    int                    num;
    fd = $fopen("testbench/ctr_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open testbench/ctr_unit_testdata.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        op       = '0;
        val      = '0;
        num      = 0;
        n = $fgets(line_buf, fd);
        n = $sscanf(line_buf, "%s", op);
        // Blank lines and lines starting with a lone # carry no record
        if (n == 1 && op != 64'("#")) begin
          if (op == 64'("LOAD") || op == 64'("EXPECT")) begin
            n = $sscanf(line_buf, "%s %h", op, val);
          end else if (op == 64'("INCR")) begin
            n = $sscanf(line_buf, "%s %d", op, num);
          end else if (op == 64'("BAD")) begin
            n = $sscanf(line_buf, "%s %b", op, val);
          end
          if (op == 64'("LOAD")) op_q.push_back(OP_LOAD);
          else if (op == 64'("INCR")) op_q.push_back(OP_INCR);
          else if (op == 64'("BAD")) op_q.push_back(OP_BAD);
          else if (op == 64'("RESET")) op_q.push_back(OP_RESET);
          else if (op == 64'("EXPECT")) op_q.push_back(OP_EXPECT);
          else begin
            $display("ERROR: unknown record %0s in testdata file", op);
            fail_cnt++;
          end
          if (op == 64'("LOAD") || op == 64'("INCR") || op == 64'("BAD") ||
              op == 64'("RESET") || op == 64'("EXPECT")) begin
            val_q.push_back(val);
            num_q.push_back(num);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Ready is sampled mid-cycle, where it is stable
  task wait_ready;
    @(negedge clk);
    while (ready !== ctr_pkg::SP2V_HIGH) @(negedge clk);
  endtask

  task load_block(input logic [BlockWidth-1:0] blk);
    wait_ready();
    @(posedge clk);
    #2;
    load     = 1'b1;
    load_ctr = to_port_order(blk);
    @(posedge clk);
    #2;
    load   = 1'b0;
    exp_be = blk;
    @(negedge clk);
    check_block("ctr_o after load", ctr, to_port_order(exp_be));
  endtask

  task increment_once;
    int busy;
    bit done;
    wait_ready();
    @(posedge clk);
    #2;
    incr = ctr_pkg::SP2V_HIGH;
    // Accepting edge
    @(posedge clk);
    #2;
    incr   = ctr_pkg::SP2V_LOW;
    exp_be = exp_be + BlockWidth'(1);
    busy   = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (ready === ctr_pkg::SP2V_HIGH || busy > NumSlices + 4) begin
        done = 1'b1;
      end else begin
        busy++;
        @(posedge clk);
        #2;
        // One cycle of load and increment while busy, both must be dropped
        if (busy == 3) begin
          load     = 1'b1;
          load_ctr = ~ctr;
          incr     = ctr_pkg::SP2V_HIGH;
        end else begin
          load = 1'b0;
          incr = ctr_pkg::SP2V_LOW;
        end
      end
    end
    if (busy != NumSlices + 1) begin
      $display("MISMATCH at %0t: ready_o low for %0d cycles, expected %0d",
               $time, busy, NumSlices + 1);
      mismatch_cnt++;
    end
    check_block("ctr_o after increment", ctr, to_port_order(exp_be));
    @(negedge clk);
    check_block("ctr_o once idle again", ctr, to_port_order(exp_be));
  endtask

  task send_illegal_code(input logic [2:0] code);
    int waited;
    wait_ready();
    @(posedge clk);
    #2;
    incr = ctr_pkg::sp2v_e'(code);
    @(posedge clk);
    #2;
    incr   = ctr_pkg::SP2V_LOW;
    waited = 0;
    while (alert !== 1'b1 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (alert !== 1'b1) begin
      $display("ERROR: alert_o did not rise after illegal code %b", code);
      fail_cnt++;
    end
    // Host keeps asking, the unit must stay locked
    @(posedge clk);
    #2;
    load     = 1'b1;
    load_ctr = ~to_port_order(exp_be);
    incr     = ctr_pkg::SP2V_HIGH;
    repeat (NumSlices + 2) begin
      @(negedge clk);
      if (alert !== 1'b1) begin
        $display("MISMATCH at %0t: alert_o dropped after illegal code", $time);
        mismatch_cnt++;
      end
      if (ready === ctr_pkg::SP2V_HIGH) begin
        $display("MISMATCH at %0t: ready_o high after illegal code", $time);
        mismatch_cnt++;
      end
      check_block("ctr_o after alert", ctr, to_port_order(exp_be));
    end
    @(posedge clk);
    #2;
    load = 1'b0;
    incr = ctr_pkg::SP2V_LOW;
  endtask

  task pulse_reset;
    @(posedge clk);
    #2;
    soft_rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    soft_rst_n = 1'b1;
    exp_be     = '0;
    @(negedge clk);
    check_reset_values();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int units;
    int gap;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'ha00));
    soft_rst_n    = 1'b1;
    load          = 1'b0;
    load_ctr      = '0;
    incr          = ctr_pkg::SP2V_LOW;
    exp_be        = '0;
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    budget_cycles = 0;
    read_testdata();
    // Budget grows with records and with each single increment
    units = 0;
    for (int i = 0; i < op_q.size(); i++) begin
      units += (op_q[i] == OP_INCR) ? num_q[i] : 1;
    end
    budget_cycles = units * (NumSlices + 10) + 100;
    wait (gen_arst_n === 1'b1);
    @(negedge clk);
    check_reset_values();
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        OP_LOAD: load_block(val_q[i]);
        OP_INCR: begin
          for (int k = 0; k < num_q[i]; k++) begin
            increment_once();
          end
        end
        OP_BAD: send_illegal_code(val_q[i][2:0]);
        OP_RESET: pulse_reset();
        default: begin
          @(negedge clk);
          check_block("EXPECT record", ctr, to_port_order(val_q[i]));
        end
      endcase
      // Random idle gap between operations
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
    end
    $display("Done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", budget_cycles);
    $display("Done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* testbench/ctr_unit_testdata.txt */
# op value: LOAD and EXPECT take a 128-bit block in hex, byte 0 (most significant) first
# INCR takes a decimal count, BAD an illegal 3-bit code in binary, RESET no value
EXPECT 00000000000000000000000000000000
INCR 1
EXPECT 00000000000000000000000000000001
LOAD 000000000000000000000000000000ff
INCR 1
EXPECT 00000000000000000000000000000100
LOAD 0000000000000000000000000000ffff
INCR 1
EXPECT 00000000000000000000000000010000
LOAD 00000000ffffffffffffffffffffffff
INCR 2
EXPECT 00000001000000000000000000000001
LOAD ffffffffffffffffffffffffffffffff
INCR 1
EXPECT 00000000000000000000000000000000
LOAD 0123456789abcdef0011223344556677
INCR 3
EXPECT 0123456789abcdef001122334455667a
BAD 000
EXPECT 0123456789abcdef001122334455667a
RESET
EXPECT 00000000000000000000000000000000
LOAD fffffffffffffffffffffffffffffffe
INCR 3
EXPECT 00000000000000000000000000000001
BAD 111
RESET
INCR 2
EXPECT 00000000000000000000000000000002

/* testbench/tb_clock_gen.sv */
/*
  Free-running clock and power-on reset for the testbench
  Reset is released 2 ns after the last reset edge
*/
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

  // Low for a fixed number of rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule
